/* compile.f */
+incdir+source
source/video_pkg.sv
source/bus_pkg.sv
source/video_timing.sv
source/video_mmr.sv
source/scroll_fetch.sv
source/color_mixer.sv
source/video_top.sv
sim/video_tb.sv

/* run_sim.sh */
#!/bin/bash
# Builds the video testbench with Verilator, runs it and scans the log for failure
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module video_tb
./obj_dir/Vvideo_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failure"

/* sim/video_tb.sv */
/*
  Testbench for the single-layer tile video subsystem.
  pxl_cen pulses on every fourth clock. Registers change only in vertical blanking,
  and the pixel check covers the whole frame that follows.
  The ROM model answers within three clocks, far inside one line.
*/
`default_nettype none
`include "video_defines.svh"

module video_tb;
    import video_pkg::*;
    import bus_pkg::*;

    localparam int CEN_DIV    = 4;
    localparam int LINE_CLKS  = `H_TOTAL * CEN_DIV;
    localparam int FRAME_CLKS = LINE_CLKS * `V_TOTAL;
    localparam int RESET_CLKS = 16;
    // Test 1 takes under two frames, each later test one frame
    localparam int TIMEOUT_CLKS = RESET_CLKS + 6 * FRAME_CLKS + LINE_CLKS;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    cpu_req_t    cpu;
    logic [15:0] cpu_rdata;
    logic        rom_valid;
    logic        rom_ready;
    rom_addr_t   rom_addr;
    logic        rom_ok;
    rom_data_t   rom_data;
    pos_t        hdump;
    pos_t        vdump;
    logic        hs;
    logic        vs;
    logic        hb_dly;
    logic        vb_dly;
    color_t      rgb;

    // Shadow of the CPU-visible state
    pos_t        sh_hpos;
    pos_t        sh_vpos;
    layer_ctrl_t sh_layer;
    color_t      sh_back;
    color_t      sh_pal [0:15];

    // Reference counters with a two-pixel delay line
    pos_t   h_ref;
    pos_t   v_ref;
    pos_t   h_d1;
    pos_t   h_d2;
    pos_t   v_d1;
    pos_t   v_d2;
    color_t exp_rgb;
    logic   chk_pix;

    // Expected ROM address of the line fetch in progress
    logic      fetch_start;
    int        fetch_word;
    int        fetch_row;
    int        fetch_col;
    rom_addr_t exp_addr;

    integer      seed;
    logic [31:0] rom_rnd;
    logic        stall_en;
    logic        accept;
    logic        pending;
    rom_addr_t   acc_addr;
    rom_addr_t   pend_addr;
    int          resp_wait;

    int cen_cnt;
    int cyc;
    int err_cnt;
    int tests_run;
    int tests_failed;
    int errs;

    video_top dut0 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .cpu(cpu), .cpu_rdata(cpu_rdata),
        .rom_valid(rom_valid), .rom_ready(rom_ready), .rom_addr(rom_addr),
        .rom_ok(rom_ok), .rom_data(rom_data), .hdump(hdump), .vdump(vdump),
        .hs(hs), .vs(vs), .hb_dly(hb_dly), .vb_dly(vb_dly), .rgb(rgb)
    );

    always #4 clk = ~clk;

    always begin
        @(posedge clk);
        #1;
        cen_cnt = (cen_cnt + 1) % CEN_DIV;
        pxl_cen = (cen_cnt == 0);
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CLKS) begin
            $display("Timeout, the run did not finish within %0d clocks", TIMEOUT_CLKS);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Word data: nibble n holds addr[3:0] + n
    function automatic rom_data_t rom_word(input rom_addr_t addr);
        rom_data_t d;
        for (int n = 0; n < `TILE_W; n++) begin
            d[4*n +: 4] = addr[3:0] + 4'(n);
        end
        return d;
    endfunction

    // ROM with one request in flight, random ready and 1 to 3 clock answers
    always begin
        @(posedge clk);
        #1;
        rom_ok = 1'b0;
        if (accept) begin
            pending   = 1'b1;
            pend_addr = acc_addr;
            rom_rnd   = $random(seed);
            resp_wait = stall_en ? int'(rom_rnd % 3) : 0;
        end
        if (pending) begin
            if (resp_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(pend_addr);
                pending  = 1'b0;
            end else begin
                resp_wait = resp_wait - 1;
            end
        end
        rom_rnd   = $random(seed);
        rom_ready = stall_en ? rom_rnd[0] : 1'b1;
        // Handshake that the next edge will see
        accept    = rom_valid && rom_ready;
        acc_addr  = rom_addr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_ref <= pos_t'(`H_TOTAL - 1);
            v_ref <= pos_t'(`V_TOTAL - 1);
            h_d1  <= pos_t'(`H_TOTAL - 1);
            h_d2  <= pos_t'(`H_TOTAL - 1);
            v_d1  <= pos_t'(`V_TOTAL - 1);
            v_d2  <= pos_t'(`V_TOTAL - 1);
        end else if (pxl_cen) begin
            if (h_ref == pos_t'(`H_TOTAL - 1)) begin
                h_ref <= '0;
                v_ref <= (v_ref == pos_t'(`V_TOTAL - 1)) ? '0 : v_ref + 1'b1;
            end else begin
                h_ref <= h_ref + 1'b1;
            end
            h_d1 <= h_ref;
            h_d2 <= h_d1;
            v_d1 <= v_ref;
            v_d2 <= v_d1;
        end
    end

    // Fetch of the next line starts one clock after the counters enter a new line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_start <= 1'b0;
            fetch_word  <= 0;
            fetch_row   <= 0;
            fetch_col   <= 0;
        end else begin
            fetch_start <= pxl_cen && (h_ref == pos_t'(`H_TOTAL - 1));
            if (fetch_start) begin
                fetch_word <= 0;
                fetch_row  <= ((int'(v_ref) + 1) % `V_TOTAL + int'(sh_vpos)) % 256;
                fetch_col  <= (int'(sh_hpos) / 8) % 32;
            end else if (rom_valid && rom_ready) begin
                fetch_word <= fetch_word + 1;
            end
        end
    end

    always_comb begin
        exp_addr = rom_addr_t'(fetch_row * 32 + (fetch_col + fetch_word) % 32);
    end

    // Tile row from (v + vpos), column from hpos/8 plus the word, fine scroll hpos mod 8
    function automatic color_t expected_rgb(input pos_t h, input pos_t v);
        int hp;
        int idx;
        int row;
        int col;
        int addr;
        int nib;
        hp   = int'(sh_hpos);
        idx  = int'(h) + hp % 8;
        row  = (int'(v) + int'(sh_vpos)) % 256;
        col  = (hp / 8 + idx / 8) % 32;
        addr = row * 32 + col;
        nib  = (addr % 16 + idx % 8) % 16;
        if (int'(h) >= `H_ACTIVE || int'(v) >= `V_ACTIVE) begin
            return '0;
        end
        if (!sh_layer[0] || nib == 0) begin
            return sh_back;
        end
        return sh_pal[4'(nib)];
    endfunction

    always_comb begin
        exp_rgb = expected_rgb(h_d2, v_d2);
    end

    task automatic report_mismatch(input string sig, input int got, input int exp);
        $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, sig, exp, got);
        err_cnt = err_cnt + 1;
    endtask

    task automatic report_error(input string msg);
        $display("t=%0t %s", $time, msg);
        err_cnt = err_cnt + 1;
    endtask

    hdump_match: assert property (@(posedge clk) disable iff (rst) hdump == h_ref)
        else report_mismatch("hdump", int'($sampled(hdump)), int'($sampled(h_ref)));
    vdump_match: assert property (@(posedge clk) disable iff (rst) vdump == v_ref)
        else report_mismatch("vdump", int'($sampled(vdump)), int'($sampled(v_ref)));
    hs_decode: assert property (@(posedge clk) disable iff (rst)
        hs == (h_ref >= pos_t'(`HS_START) && h_ref < pos_t'(`HS_END)))
        else report_mismatch("hs", int'($sampled(hs)), int'(!$sampled(hs)));
    vs_decode: assert property (@(posedge clk) disable iff (rst)
        vs == (v_ref >= pos_t'(`VS_START) && v_ref < pos_t'(`VS_END)))
        else report_mismatch("vs", int'($sampled(vs)), int'(!$sampled(vs)));
    hb_delay: assert property (@(posedge clk) disable iff (rst)
        hb_dly == (h_d2 >= pos_t'(`H_ACTIVE)))
        else report_mismatch("hb_dly", int'($sampled(hb_dly)), int'(!$sampled(hb_dly)));
    vb_delay: assert property (@(posedge clk) disable iff (rst)
        vb_dly == (v_d2 >= pos_t'(`V_ACTIVE)))
        else report_mismatch("vb_dly", int'($sampled(vb_dly)), int'(!$sampled(vb_dly)));
    blank_black: assert property (@(posedge clk) disable iff (rst)
        (hb_dly || vb_dly) |-> rgb == '0)
        else report_mismatch("rgb", int'($sampled(rgb)), 0);
    pixel_match: assert property (@(posedge clk) disable iff (rst)
        (chk_pix && !hb_dly && !vb_dly) |-> rgb == exp_rgb)
        else report_mismatch("rgb", int'($sampled(rgb)), int'($sampled(exp_rgb)));
    rom_hold: assert property (@(posedge clk) disable iff (rst)
        (rom_valid && !rom_ready) |=> (rom_valid && $stable(rom_addr)))
        else report_error("rom_addr or rom_valid changed while rom_ready was low");
    fetch_addr: assert property (@(posedge clk) disable iff (rst)
        (rom_valid && rom_ready) |-> rom_addr == exp_addr)
        else report_mismatch("rom_addr", int'($sampled(rom_addr)), int'($sampled(exp_addr)));

    task automatic cpu_write(input logic [4:0] addr, input logic [15:0] data);
        @(posedge clk);
        #1;
        cpu.cs   = 1'b1;
        cpu.we   = 1'b1;
        cpu.addr = addr;
        cpu.data = data;
        @(posedge clk);
        #1;
        cpu = '0;
        if (addr[4]) begin
            sh_pal[addr[3:0]] = data[11:0];
        end else begin
            case (addr)
                5'(`REG_HPOS):       sh_hpos  = data[8:0];
                5'(`REG_VPOS):       sh_vpos  = data[8:0];
                5'(`REG_LAYER_CTRL): sh_layer = data;
                5'(`REG_BACK_COLOR): sh_back  = data[11:0];
                default: ;
            endcase
        end
    endtask

    task automatic cpu_read(input logic [4:0] addr, output logic [15:0] data);
        @(posedge clk);
        #1;
        cpu.cs   = 1'b1;
        cpu.we   = 1'b0;
        cpu.addr = addr;
        cpu.data = '0;
        @(posedge clk);
        #1;
        cpu  = '0;
        data = cpu_rdata;
    endtask

    task automatic read_check(input logic [4:0] addr, input logic [15:0] exp);
        logic [15:0] got;
        cpu_read(addr, got);
        assert (got == exp) else report_mismatch("cpu_rdata", int'(got), int'(exp));
    endtask

    // Returns on a fresh start of the given line
    task automatic wait_line(input int line);
        while (hdump == '0 && vdump == pos_t'(line)) begin
            @(posedge clk);
            #1;
        end
        while (!(hdump == '0 && vdump == pos_t'(line))) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Called in vertical blanking after setup, ends in the next blanking
    task automatic check_frame;
        wait_line(0);
        chk_pix = 1'b1;
        wait_line(`V_ACTIVE);
        chk_pix = 1'b0;
    endtask

    task automatic load_palette;
        for (int i = 0; i < 16; i++) begin
            cpu_write(5'(16 + i), {4'd0, 4'(i), 4'(15 - i), 4'(i * 7)});
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (err_cnt == errs_before) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     err_cnt - errs_before);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        pxl_cen      = 1'b0;
        cpu          = '0;
        rom_ready    = 1'b0;
        rom_ok       = 1'b0;
        rom_data     = '0;
        seed         = 95;
        stall_en     = 1'b0;
        accept       = 1'b0;
        pending      = 1'b0;
        acc_addr     = '0;
        pend_addr    = '0;
        resp_wait    = 0;
        chk_pix      = 1'b0;
        cen_cnt      = 0;
        cyc          = 0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        sh_hpos      = '0;
        sh_vpos      = '0;
        sh_layer     = '0;
        sh_back      = '0;
        for (int i = 0; i < 16; i++) begin
            sh_pal[i] = '0;
        end

        repeat (RESET_CLKS) @(posedge clk);
        #1;
        errs = err_cnt;
        assert (rgb == '0) else report_mismatch("rgb", int'(rgb), 0);
        assert (hs == 1'b0) else report_mismatch("hs", int'(hs), 0);
        assert (vs == 1'b0) else report_mismatch("vs", int'(vs), 0);
        assert (rom_valid == 1'b0) else report_mismatch("rom_valid", int'(rom_valid), 0);
        rst = 1'b0;
        // One whole frame of counter, sync and blanking checks
        wait_line(`V_ACTIVE);
        wait_line(`V_ACTIVE);
        finish_test("reset, counters and sync", errs);

        errs = err_cnt;
        cpu_write(5'(`REG_HPOS), {7'd0, 9'h155});
        cpu_write(5'(`REG_VPOS), {7'd0, 9'h0aa});
        cpu_write(5'(`REG_LAYER_CTRL), 16'ha5a4);
        cpu_write(5'(`REG_BACK_COLOR), {4'd0, 12'h9c3});
        cpu_write(5'd21, {4'd0, 12'hfff});
        read_check(5'(`REG_HPOS), {7'd0, sh_hpos});
        read_check(5'(`REG_VPOS), {7'd0, sh_vpos});
        read_check(5'(`REG_LAYER_CTRL), sh_layer);
        read_check(5'(`REG_BACK_COLOR), {4'd0, sh_back});
        read_check(5'd21, 16'h0000);
        finish_test("register readback", errs);

        errs = err_cnt;
        load_palette();
        cpu_write(5'(`REG_HPOS), 16'h0000);
        cpu_write(5'(`REG_VPOS), 16'h0000);
        cpu_write(5'(`REG_BACK_COLOR), {4'd0, 12'h2d6});
        cpu_write(5'(`REG_LAYER_CTRL), 16'h0001);
        check_frame();
        finish_test("picture without scroll", errs);

        // Column and row both wrap with these offsets
        errs = err_cnt;
        cpu_write(5'(`REG_HPOS), {7'd0, 9'h0fd});
        cpu_write(5'(`REG_VPOS), {7'd0, 9'h0f5});
        check_frame();
        finish_test("picture with scroll", errs);

        errs = err_cnt;
        cpu_write(5'(`REG_LAYER_CTRL), 16'h0000);
        cpu_write(5'(`REG_BACK_COLOR), {4'd0, 12'h5a3});
        check_frame();
        finish_test("layer disabled", errs);

        errs = err_cnt;
        stall_en = 1'b1;
        cpu_write(5'(`REG_LAYER_CTRL), 16'h0001);
        check_frame();
        finish_test("ROM stalls", errs);

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/bus_pkg.sv */
/*
  CPU access and graphics ROM types.
  The CPU port is a single-cycle strobe without handshake.
  A ROM word holds eight 4-bit pixels, leftmost pixel in the low nibble.
*/
`default_nettype none

package bus_pkg;

    typedef struct packed {
        logic        cs;
        logic        we;
        logic [4:0]  addr;
        logic [15:0] data;
    } cpu_req_t;

    // Row times 32 plus tile column
    typedef logic [12:0] rom_addr_t;

    typedef logic [31:0] rom_data_t;

endpackage

`default_nettype wire

/* source/color_mixer.sv */
/*
  Palette lookup and final colour select for the scroll layer.
  The pixel arrives one pxl_cen behind the counters, the blanking inputs arrive with
  the counters, and both leave two pxl_cen behind the counters.
  Output is black during blanking.
*/
`default_nettype none

module color_mixer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pxl_cen,
    input  wire                         hb,
    input  wire                         vb,
    input  wire video_pkg::pxl_idx_t    pxl,
    input  wire video_pkg::layer_ctrl_t layer_ctrl,
    input  wire video_pkg::color_t      back_color,
    input  wire video_pkg::pal_wr_t     pal_wr,
    output video_pkg::color_t           rgb,
    output logic                        hb_dly,
    output logic                        vb_dly
);
    import video_pkg::*;

    color_t pal_ram [0:15];
    color_t pal_color;
    logic   show_back;
    logic   hb1;
    logic   vb1;

    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.entry] <= pal_wr.color;
        end
    end

    assign pal_color = pal_ram[pxl];
    // Index 0 is transparent and lets the background through
    assign show_back = !layer_ctrl[0] || (pxl == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb1    <= 1'b1;
            vb1    <= 1'b1;
            hb_dly <= 1'b1;
            vb_dly <= 1'b1;
            rgb    <= '0;
        end else if (pxl_cen) begin
            // First stage brings blanking level with the pixel
            hb1    <= hb;
            vb1    <= vb;
            hb_dly <= hb1;
            vb_dly <= vb1;
            if (hb1 || vb1) begin
                rgb <= '0;
            end else if (show_back) begin
                rgb <= back_color;
            end else begin
                rgb <= pal_color;
            end
        end
    end

    black_in_blank: assert property (@(posedge clk) disable iff (rst)
        (hb_dly || vb_dly) |-> rgb == '0);

endmodule

`default_nettype wire

/* source/scroll_fetch.sv */
/*
  Line fetch and pixel read-out for one 8x8 tile scroll layer.
  Each line_start fetches nine ROM words for the next line into the idle buffer half.
  The ROM must return all nine words within one line, a late fetch is not detected.
  A line_start that arrives while a fetch is still running is ignored.
*/
`default_nettype none
`include "video_defines.svh"

module scroll_fetch (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     pxl_cen,
    input  wire                     line_start,
    input  wire video_pkg::pos_t    vrender,
    input  wire video_pkg::pos_t    vdump,
    input  wire video_pkg::pos_t    hdump,
    input  wire video_pkg::pos_t    hpos,
    input  wire video_pkg::pos_t    vpos,
    output logic                    rom_valid,
    input  wire                     rom_ready,
    output bus_pkg::rom_addr_t      rom_addr,
    input  wire                     rom_ok,
    input  wire bus_pkg::rom_data_t rom_data,
    output video_pkg::pxl_idx_t     pxl
);
    import video_pkg::*;

    localparam int BUF_LEN = `FETCH_WORDS * `TILE_W;

    typedef enum logic [1:0] {st_idle, st_req, st_wait} fetch_st_t;

    fetch_st_t  state;
    logic [3:0] word_cnt;
    logic [7:0] row;
    logic [4:0] col;
    logic       wr_half;
    pos_t       row_sum;
    logic [6:0] rd_idx;
    logic       last_word;
    pxl_idx_t   line_buf [0:1][0:BUF_LEN-1];

    assign row_sum   = vrender + vpos;
    assign last_word = (word_cnt == 4'(`FETCH_WORDS - 1));
    assign rom_valid = (state == st_req);
    // Tile row in the upper bits, column wraps at 32 tiles
    assign rom_addr  = {row, col + 5'(word_cnt)};
    // Fine scroll shifts the read point into the extra tile
    assign rd_idx    = hdump[6:0] + 7'(hpos[2:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            word_cnt <= '0;
            row      <= '0;
            col      <= '0;
            wr_half  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (line_start) begin
                        row      <= row_sum[7:0];
                        col      <= hpos[7:3];
                        wr_half  <= vrender[0];
                        word_cnt <= '0;
                        state    <= st_req;
                    end
                end
                st_req: begin
                    if (rom_ready) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (rom_ok) begin
                        word_cnt <= word_cnt + 1'b1;
                        state    <= last_word ? st_idle : st_req;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Eight pixels per word, leftmost in the low nibble
    always_ff @(posedge clk) begin
        if (state == st_wait && rom_ok) begin
            for (int k = 0; k < `TILE_W; k++) begin
                line_buf[wr_half][{word_cnt, 3'(k)}] <= rom_data[4*k +: 4];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            if (hdump < pos_t'(`H_ACTIVE)) begin
                pxl <= line_buf[vdump[0]][rd_idx];
            end else begin
                pxl <= '0;
            end
        end
    end

    rom_addr_hold: assert property (@(posedge clk) disable iff (rst)
        rom_valid && !rom_ready |=> rom_valid && $stable(rom_addr));

    rom_ok_expected: assert property (@(posedge clk) disable iff (rst)
        rom_ok |-> state == st_wait);

endmodule

`default_nettype wire

/* source/video_defines.svh */
/*
  Screen geometry, tile size and CPU register map of the video subsystem.
  Horizontal values count pixel clock enables and vertical values count lines.
  Register addresses are word addresses and the palette fills addresses 16 to 31.
*/
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal timing
`define H_ACTIVE    64
`define H_TOTAL     96
`define HS_START    72
`define HS_END      80

// Vertical timing
`define V_ACTIVE    32
`define V_TOTAL     40
`define VS_START    34
`define VS_END      36

// One ROM word is one tile row
`define TILE_W      8
// Active width plus one tile for fine scroll
`define FETCH_WORDS 9

`define REG_HPOS        0
`define REG_VPOS        1
`define REG_LAYER_CTRL  2
`define REG_BACK_COLOR  3

`endif

/* source/video_mmr.sv */
/*
  CPU-visible registers of the scroll layer.
  Writes to addresses 4 to 15 are dropped and those addresses read as zero.
  Palette entries are write-only and read back as zero.
*/
`default_nettype none
`include "video_defines.svh"

module video_mmr (
    input  wire                     clk,
    input  wire                     rst,
    input  wire bus_pkg::cpu_req_t  cpu,
    output logic [15:0]             cpu_rdata,
    output video_pkg::pos_t         hpos,
    output video_pkg::pos_t         vpos,
    output video_pkg::layer_ctrl_t  layer_ctrl,
    output video_pkg::color_t       back_color,
    output video_pkg::pal_wr_t      pal_wr
);
    logic wr_en;
    logic rd_en;
    logic pal_sel;

    assign wr_en   = cpu.cs && cpu.we;
    assign rd_en   = cpu.cs && !cpu.we;
    // Upper half of the word space is the palette
    assign pal_sel = cpu.addr[4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hpos       <= '0;
            vpos       <= '0;
            layer_ctrl <= '0;
            back_color <= '0;
        end else if (wr_en && !pal_sel) begin
            case (cpu.addr)
                5'(`REG_HPOS):       hpos       <= cpu.data[8:0];
                5'(`REG_VPOS):       vpos       <= cpu.data[8:0];
                5'(`REG_LAYER_CTRL): layer_ctrl <= cpu.data;
                5'(`REG_BACK_COLOR): back_color <= cpu.data[11:0];
                default: ;
            endcase
        end
    end

    // Palette write leaves one clock after the CPU write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_wr <= '0;
        end else begin
            pal_wr.we    <= wr_en && pal_sel;
            pal_wr.entry <= cpu.addr[3:0];
            pal_wr.color <= cpu.data[11:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_rdata <= '0;
        end else if (rd_en) begin
            case (cpu.addr)
                5'(`REG_HPOS):       cpu_rdata <= {7'd0, hpos};
                5'(`REG_VPOS):       cpu_rdata <= {7'd0, vpos};
                5'(`REG_LAYER_CTRL): cpu_rdata <= layer_ctrl;
                5'(`REG_BACK_COLOR): cpu_rdata <= {4'd0, back_color};
                default:             cpu_rdata <= '0;
            endcase
        end
    end

    pal_wr_origin: assert property (@(posedge clk) disable iff (rst)
        pal_wr.we |-> $past(wr_en && pal_sel));

endmodule

`default_nettype wire

/* source/video_pkg.sv */
/*
  Types shared by the video pipeline.
  Colours are 4 bits per channel with red in the top nibble and blue in the low one.
  Palette index 0 is transparent.
*/
`default_nettype none

package video_pkg;

    // Pixel counter or scroll offset
    typedef logic [8:0] pos_t;

    // Palette index of one pixel
    typedef logic [3:0] pxl_idx_t;

    typedef logic [11:0] color_t;

    // Bit 0 enables the scroll layer
    typedef logic [15:0] layer_ctrl_t;

    // One-clock palette write pulse
    typedef struct packed {
        logic     we;
        pxl_idx_t entry;
        color_t   color;
    } pal_wr_t;

endpackage

`default_nettype wire

/* source/video_timing.sv */
/*
  Pixel and line counters with registered sync and blanking.
  Everything advances only on pxl_cen and resets into blanking at the last pixel
  of the last line, so the first counted pixel is (0, 0).
*/
`default_nettype none
`include "video_defines.svh"

module video_timing (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 pxl_cen,
    output video_pkg::pos_t     hdump,
    output video_pkg::pos_t     vdump,
    output video_pkg::pos_t     vrender,
    output logic                line_start,
    output logic                hs,
    output logic                vs,
    output logic                hb,
    output logic                vb
);
    import video_pkg::*;

    pos_t h_nxt;
    pos_t v_nxt;
    logic h_wrap;

    // Next counter values, decodes are taken from these so they line up with the counters
    always_comb begin
        h_wrap = (hdump == pos_t'(`H_TOTAL - 1));
        h_nxt  = h_wrap ? '0 : hdump + 1'b1;
        v_nxt  = vdump;
        if (h_wrap) begin
            v_nxt = (vdump == pos_t'(`V_TOTAL - 1)) ? '0 : vdump + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump      <= pos_t'(`H_TOTAL - 1);
            vdump      <= pos_t'(`V_TOTAL - 1);
            vrender    <= '0;
            line_start <= 1'b0;
            hs         <= 1'b0;
            vs         <= 1'b0;
            hb         <= 1'b1;
            vb         <= 1'b1;
        end else begin
            line_start <= 1'b0;
            if (pxl_cen) begin
                hdump      <= h_nxt;
                vdump      <= v_nxt;
                // Line being fetched is one ahead of the one on screen
                vrender    <= (v_nxt == pos_t'(`V_TOTAL - 1)) ? '0 : v_nxt + 1'b1;
                line_start <= (h_nxt == '0);
                hs         <= (h_nxt >= pos_t'(`HS_START)) && (h_nxt < pos_t'(`HS_END));
                vs         <= (v_nxt >= pos_t'(`VS_START)) && (v_nxt < pos_t'(`VS_END));
                hb         <= (h_nxt >= pos_t'(`H_ACTIVE));
                vb         <= (v_nxt >= pos_t'(`V_ACTIVE));
            end
        end
    end

    vdump_range: assert property (@(posedge clk) disable iff (rst)
        vdump < pos_t'(`V_TOTAL));

endmodule

`default_nettype wire

/* source/video_top.sv */
/*
  Single-layer tile video subsystem.
  rgb and the delayed blanking for pixel (h, v) follow hdump and vdump by two pxl_cen.
  The ROM must finish one line's nine words within one line period.
*/
`default_nettype none

module video_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     pxl_cen,
    input  wire bus_pkg::cpu_req_t  cpu,
    output logic [15:0]             cpu_rdata,
    output logic                    rom_valid,
    input  wire                     rom_ready,
    output bus_pkg::rom_addr_t      rom_addr,
    input  wire                     rom_ok,
    input  wire bus_pkg::rom_data_t rom_data,
    output video_pkg::pos_t         hdump,
    output video_pkg::pos_t         vdump,
    output logic                    hs,
    output logic                    vs,
    output logic                    hb_dly,
    output logic                    vb_dly,
    output video_pkg::color_t       rgb
);
    import video_pkg::*;

    pos_t        vrender;
    logic        line_start;
    logic        hb;
    logic        vb;
    pos_t        hpos;
    pos_t        vpos;
    layer_ctrl_t layer_ctrl;
    color_t      back_color;
    pal_wr_t     pal_wr;
    pxl_idx_t    pxl;

    video_timing u_timing (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump), .vrender(vrender), .line_start(line_start),
        .hs(hs), .vs(vs), .hb(hb), .vb(vb)
    );

    video_mmr u_mmr (
        .clk(clk), .rst(rst), .cpu(cpu), .cpu_rdata(cpu_rdata),
        .hpos(hpos), .vpos(vpos), .layer_ctrl(layer_ctrl),
        .back_color(back_color), .pal_wr(pal_wr)
    );

    scroll_fetch u_fetch (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .line_start(line_start),
        .vrender(vrender), .vdump(vdump), .hdump(hdump),
        .hpos(hpos), .vpos(vpos),
        .rom_valid(rom_valid), .rom_ready(rom_ready), .rom_addr(rom_addr),
        .rom_ok(rom_ok), .rom_data(rom_data), .pxl(pxl)
    );

    color_mixer u_mixer (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hb(hb), .vb(vb), .pxl(pxl),
        .layer_ctrl(layer_ctrl), .back_color(back_color), .pal_wr(pal_wr),
        .rgb(rgb), .hb_dly(hb_dly), .vb_dly(vb_dly)
    );

endmodule

`default_nettype wire
